// ==== source/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data and instruction width
`define CORE_XLEN 32

// register index width for 32 registers
`define CORE_REG_ADDR_WIDTH 5

// instruction memory word address for 64 words
`define CORE_IMEM_ADDR_WIDTH 6

// trace credits granted after reset
`define CORE_TRACE_CREDITS 4
`define CORE_CREDIT_WIDTH 3

`endif

// ==== source/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDI  = 6'd8,
        OP_HALT  = 6'd63
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_e;

    typedef enum logic [2:0] {FLOW_NONE, FLOW_BEQ, FLOW_BNE, FLOW_JUMP, FLOW_HALT} flow_e;

    typedef enum logic [1:0] {RUN_IDLE, RUN_ACTIVE, RUN_HALTED} run_state_e;

    typedef struct packed {
        logic                             valid;
        logic [`CORE_IMEM_ADDR_WIDTH-1:0] addr;
        logic [`CORE_XLEN-1:0]            word;
    } load_t;

    typedef struct packed {
        logic                             valid;
        logic [`CORE_IMEM_ADDR_WIDTH-1:0] pc;
        logic [`CORE_XLEN-1:0]            instr;
    } fetch_t;

    typedef struct packed {
        logic                             valid;
        alu_op_e                          alu_op;
        flow_e                            flow;
        logic [`CORE_XLEN-1:0]            op_a;
        logic [`CORE_XLEN-1:0]            op_b;
        // rt value for beq and bne
        logic [`CORE_XLEN-1:0]            cmp;
        logic [`CORE_REG_ADDR_WIDTH-1:0]  dest;
        logic                             we;
        logic [`CORE_IMEM_ADDR_WIDTH-1:0] target;
    } decode_t;

    // trace record and register file write
    typedef struct packed {
        logic                            valid;
        logic [`CORE_REG_ADDR_WIDTH-1:0] dest;
        logic [`CORE_XLEN-1:0]           value;
    } retire_t;

endpackage

// ==== source/pipeline_control.sv ====
`timescale 1ns/1ns

module pipeline_control (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic wants_retire,
    input  logic redirect,
    input  logic halt_seen,
    input  logic credits_available,
    output logic run,
    output logic stall,
    output logic flush,
    output logic record_fire,
    output logic halted
);

    core_pkg::run_state_e state, state_next;

    always_comb begin
        state_next = state;
        case (state)
            core_pkg::RUN_IDLE: begin
                if (start)
                    state_next = core_pkg::RUN_ACTIVE;
            end
            core_pkg::RUN_ACTIVE: begin
                if (halt_seen)
                    state_next = core_pkg::RUN_HALTED;
            end
            // halted is left only through reset
            default: state_next = state;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= core_pkg::RUN_IDLE;
        else
            state <= state_next;
    end

    assign run    = (state == core_pkg::RUN_ACTIVE);
    assign halted = (state == core_pkg::RUN_HALTED);

    // hold the pipe while a record waits for a credit
    assign stall       = wants_retire && !credits_available;
    assign flush       = redirect || halt_seen;
    assign record_fire = wants_retire && !stall;

endmodule

// ==== source/credit_counter.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic record_fire,
    input  logic credit_return,
    output logic credits_available
);

    logic [`CORE_CREDIT_WIDTH-1:0] count;

    // fire and return in the same cycle cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= `CORE_CREDIT_WIDTH'(`CORE_TRACE_CREDITS);
        end else if (record_fire && !credit_return) begin
            count <= count - 1'b1;
        end else if (credit_return && !record_fire) begin
            count <= count + 1'b1;
        end
    end

    assign credits_available = (count != '0);

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module fetch_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  core_pkg::load_t                  load,
    input  logic                             run,
    input  logic                             stall,
    input  logic                             flush,
    input  logic                             redirect,
    input  logic [`CORE_IMEM_ADDR_WIDTH-1:0] redirect_target,
    output core_pkg::fetch_t                 fetched
);

    logic [`CORE_XLEN-1:0] imem [0:(1 << `CORE_IMEM_ADDR_WIDTH)-1];
    logic [`CORE_IMEM_ADDR_WIDTH-1:0] pc;

    // load port writes one word per cycle
    always_ff @(posedge clk) begin
        if (load.valid)
            imem[load.addr] <= load.word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            fetched <= '0;
        end else if (redirect) begin
            pc            <= redirect_target;
            fetched.valid <= 1'b0;
        end else if (flush) begin
            fetched.valid <= 1'b0;
        end else if (!stall) begin
            if (run) begin
                fetched.valid <= 1'b1;
                fetched.pc    <= pc;
                fetched.instr <= imem[pc];
                pc            <= pc + 1'b1;
            end else begin
                fetched.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::fetch_t  fetched,
    input  logic              stall,
    input  logic              flush,
    input  core_pkg::retire_t retire,
    output core_pkg::decode_t decoded
);

    logic [`CORE_XLEN-1:0] regs [0:(1 << `CORE_REG_ADDR_WIDTH)-1];

    logic [`CORE_REG_ADDR_WIDTH-1:0] rs, rt, rd;
    logic [`CORE_XLEN-1:0]           rs_val, rt_val, imm_ext;
    core_pkg::decode_t               decode_d;

    // zero register reads 0 and a same-cycle retire wins
    function automatic logic [`CORE_XLEN-1:0] read_reg(
        input logic [`CORE_REG_ADDR_WIDTH-1:0] idx
    );
        if (idx == '0)
            return '0;
        else if (retire.valid && retire.dest == idx)
            return retire.value;
        else
            return regs[idx];
    endfunction

    assign rs      = fetched.instr[25:21];
    assign rt      = fetched.instr[20:16];
    assign rd      = fetched.instr[15:11];
    assign imm_ext = {{(`CORE_XLEN-16){fetched.instr[15]}}, fetched.instr[15:0]};

    always_comb begin
        rs_val = read_reg(rs);
        rt_val = read_reg(rt);
    end

    always_ff @(posedge clk) begin
        if (retire.valid)
            regs[retire.dest] <= retire.value;
    end

    always_comb begin
        decode_d        = '0;
        decode_d.valid  = fetched.valid;
        decode_d.alu_op = core_pkg::ALU_ADD;
        decode_d.flow   = core_pkg::FLOW_NONE;
        decode_d.op_a   = rs_val;
        decode_d.op_b   = rt_val;
        decode_d.cmp    = rt_val;
        decode_d.dest   = rd;
        // branch target is pc+1 plus the word offset
        decode_d.target = fetched.pc + 1'b1 + imm_ext[`CORE_IMEM_ADDR_WIDTH-1:0];
        case (core_pkg::opcode_e'(fetched.instr[31:26]))
            core_pkg::OP_RTYPE: begin
                decode_d.we = 1'b1;
                case (core_pkg::funct_e'(fetched.instr[5:0]))
                    core_pkg::FN_ADD: decode_d.alu_op = core_pkg::ALU_ADD;
                    core_pkg::FN_SUB: decode_d.alu_op = core_pkg::ALU_SUB;
                    core_pkg::FN_AND: decode_d.alu_op = core_pkg::ALU_AND;
                    core_pkg::FN_OR:  decode_d.alu_op = core_pkg::ALU_OR;
                    core_pkg::FN_SLT: decode_d.alu_op = core_pkg::ALU_SLT;
                    // unknown funct runs as a no-op
                    default:          decode_d.we = 1'b0;
                endcase
            end
            core_pkg::OP_ADDI: begin
                decode_d.op_b = imm_ext;
                decode_d.dest = rt;
                decode_d.we   = 1'b1;
            end
            core_pkg::OP_BEQ:  decode_d.flow = core_pkg::FLOW_BEQ;
            core_pkg::OP_BNE:  decode_d.flow = core_pkg::FLOW_BNE;
            core_pkg::OP_J: begin
                decode_d.flow   = core_pkg::FLOW_JUMP;
                decode_d.target = fetched.instr[`CORE_IMEM_ADDR_WIDTH-1:0];
            end
            core_pkg::OP_HALT: decode_d.flow = core_pkg::FLOW_HALT;
            default: decode_d.we = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            decoded <= '0;
        else if (flush)
            decoded.valid <= 1'b0;
        else if (!stall)
            decoded <= decode_d;
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module execute_stage (
    input  core_pkg::decode_t                decoded,
    input  logic                             stall,
    output core_pkg::retire_t                retire,
    output logic                             wants_retire,
    output logic                             redirect,
    output logic                             halt_seen,
    output logic [`CORE_IMEM_ADDR_WIDTH-1:0] redirect_target
);

    logic [`CORE_XLEN-1:0] result;
    logic                  taken;

    always_comb begin
        case (decoded.alu_op)
            core_pkg::ALU_ADD: result = decoded.op_a + decoded.op_b;
            core_pkg::ALU_SUB: result = decoded.op_a - decoded.op_b;
            core_pkg::ALU_AND: result = decoded.op_a & decoded.op_b;
            core_pkg::ALU_OR:  result = decoded.op_a | decoded.op_b;
            core_pkg::ALU_SLT: begin
                result = '0;
                result[0] = $signed(decoded.op_a) < $signed(decoded.op_b);
            end
            default:           result = decoded.op_a + decoded.op_b;
        endcase
    end

    // branch compare and jump resolution
    always_comb begin
        case (decoded.flow)
            core_pkg::FLOW_BEQ:  taken = (decoded.op_a == decoded.cmp);
            core_pkg::FLOW_BNE:  taken = (decoded.op_a != decoded.cmp);
            core_pkg::FLOW_JUMP: taken = 1'b1;
            default:             taken = 1'b0;
        endcase
    end

    assign redirect        = decoded.valid && taken;
    assign redirect_target = decoded.target;
    assign halt_seen       = decoded.valid && (decoded.flow == core_pkg::FLOW_HALT);

    // writes to r0 never leave as records
    assign wants_retire = decoded.valid && decoded.we && (decoded.dest != '0);

    assign retire.valid = wants_retire && !stall;
    assign retire.dest  = decoded.dest;
    assign retire.value = result;

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_top (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::load_t   load,
    input  logic              start,
    input  logic              credit_return,
    output core_pkg::retire_t trace,
    output logic              halted
);

    core_pkg::fetch_t  fetched;
    core_pkg::decode_t decoded;

    logic run, stall, flush, record_fire;
    logic wants_retire, redirect, halt_seen;
    logic credits_available;
    logic [`CORE_IMEM_ADDR_WIDTH-1:0] redirect_target;

    pipeline_control pipeline_control_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .wants_retire      (wants_retire),
        .redirect          (redirect),
        .halt_seen         (halt_seen),
        .credits_available (credits_available),
        .run               (run),
        .stall             (stall),
        .flush             (flush),
        .record_fire       (record_fire),
        .halted            (halted)
    );

    credit_counter credit_counter_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .record_fire       (record_fire),
        .credit_return     (credit_return),
        .credits_available (credits_available)
    );

    fetch_stage fetch_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .load            (load),
        .run             (run),
        .stall           (stall),
        .flush           (flush),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .fetched         (fetched)
    );

    // retire record feeds the register file and leaves as the trace
    decode_stage decode_stage_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .fetched (fetched),
        .stall   (stall),
        .flush   (flush),
        .retire  (trace),
        .decoded (decoded)
    );

    execute_stage execute_stage_i (
        .decoded         (decoded),
        .stall           (stall),
        .retire          (trace),
        .wants_retire    (wants_retire),
        .redirect        (redirect),
        .halt_seen       (halt_seen),
        .redirect_target (redirect_target)
    );

endmodule

// ==== test/core_props.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_props (
    input logic                           clk,
    input logic                           rst_n,
    input core_pkg::retire_t              trace,
    input logic                           halted,
    input logic                           credits_available,
    input logic [`CORE_CREDIT_WIDTH-1:0]  credit_count
);

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        credit_count <= `CORE_CREDIT_WIDTH'(`CORE_TRACE_CREDITS))
        else $error("credit count above the reset value");

    record_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        trace.valid |-> credits_available)
        else $error("trace record while no credit is left");

    halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted fell before reset");

    // r0 writes stay inside the core
    no_zero_dest: assert property (@(posedge clk) disable iff (!rst_n)
        trace.valid |-> (trace.dest != '0))
        else $error("trace record for register 0");

endmodule

bind core_top core_props core_props_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .trace             (trace),
    .halted            (halted),
    .credits_available (credits_available),
    .credit_count      (credit_counter_i.count)
);

// ==== test/core_tb.sv ====
`timescale 1ns/1ns
`include "core_config.svh"

module core_tb;

    localparam int record_timeout = 1000;
    localparam int halt_timeout   = 200;
    localparam int quiet_cycles   = 50;

    logic              clk;
    logic              rst_n;
    core_pkg::load_t   load;
    logic              start;
    logic              credit_return;
    core_pkg::retire_t trace;
    logic              halted;

    logic [31:0] prog_words [$];
    logic        return_sched [$];
    logic [31:0] exp_dest [$];
    logic [31:0] exp_value [$];

    int n_recv;
    int n_issued;
    int returns_applied;
    int sched_idx;
    bit halted_seen;

    core_top core_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .start         (start),
        .credit_return (credit_return),
        .trace         (trace),
        .halted        (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            $display("malformed line in test/core_input.txt");
            stop_with_failure();
        end
    endtask

    task automatic read_input();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [8*128-1:0] rest;
        logic [31:0]      w0, w1, w2, w3;
        logic [15:0]      mask;
        fd = $fopen("test/core_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/core_input.txt");
            stop_with_failure();
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                case (tag)
                    "#": code = $fgets(rest, fd);
                    "p": begin
                        code = $fscanf(fd, "%h %h %h %h", w0, w1, w2, w3);
                        require_fields(code, 4);
                        prog_words.push_back(w0);
                        prog_words.push_back(w1);
                        prog_words.push_back(w2);
                        prog_words.push_back(w3);
                    end
                    // leftmost bit is the earliest cycle
                    "c": begin
                        code = $fscanf(fd, "%b", mask);
                        require_fields(code, 1);
                        for (int i = 15; i >= 0; i--)
                            return_sched.push_back(mask[i]);
                    end
                    "e": begin
                        code = $fscanf(fd, "%d %h", w0, w1);
                        require_fields(code, 2);
                        exp_dest.push_back(w0);
                        exp_value.push_back(w1);
                    end
                    default: begin
                        $display("unknown line kind in test/core_input.txt");
                        stop_with_failure();
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    task automatic load_program();
        core_pkg::load_t word_in;
        for (int i = 0; i < prog_words.size(); i++) begin
            word_in.valid = 1'b1;
            word_in.addr  = `CORE_IMEM_ADDR_WIDTH'(i);
            word_in.word  = prog_words[i];
            @(posedge clk);
            load <= word_in;
        end
        @(posedge clk);
        load <= '0;
    endtask

    task automatic check_record();
        if (n_recv >= exp_value.size()) begin
            $display("record for register %0d arrived after the last expected one",
                     trace.dest);
            stop_with_failure();
        end else begin
            check_value("trace.dest", 32'(trace.dest), exp_dest[n_recv]);
            check_value("trace.value", trace.value, exp_value[n_recv]);
            n_recv++;
            check_value("trace.valid within granted credits",
                        32'(n_recv <= `CORE_TRACE_CREDITS + returns_applied), 32'd1);
        end
    endtask

    // drive credits at the rising edge and sample at the falling edge
    task automatic step_cycle();
        logic give;
        @(posedge clk);
        // a return driven last cycle lands at this edge
        if (credit_return)
            returns_applied++;
        give = 1'b1;
        if (sched_idx < return_sched.size()) begin
            give = return_sched[sched_idx];
            sched_idx++;
        end
        // never more returns than records seen
        if (give && n_recv > n_issued) begin
            if (n_issued == 0)
                check_value("records before first credit return", n_recv,
                            `CORE_TRACE_CREDITS);
            credit_return <= 1'b1;
            n_issued++;
        end else begin
            credit_return <= 1'b0;
        end
        @(negedge clk);
        if (trace.valid)
            check_record();
        if (halted_seen)
            check_value("halted", 32'(halted), 32'd1);
        halted_seen = halted_seen || halted;
    endtask

    initial begin
        int cycles;
        rst_n           = 1'b0;
        load            = '0;
        start           = 1'b0;
        credit_return   = 1'b0;
        n_recv          = 0;
        n_issued        = 0;
        returns_applied = 0;
        sched_idx       = 0;
        halted_seen     = 1'b0;
        read_input();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        load_program();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        cycles = 0;
        while (n_recv < exp_value.size()) begin
            if (cycles == record_timeout) begin
                $display("timeout: %0d of %0d records arrived", n_recv, exp_value.size());
                stop_with_failure();
            end else begin
                step_cycle();
                cycles++;
            end
        end

        cycles = 0;
        while (!halted_seen) begin
            if (cycles == halt_timeout) begin
                $display("timeout: halted never rose after the last record");
                stop_with_failure();
            end else begin
                step_cycle();
                cycles++;
            end
        end

        // quiet window after halt
        for (int i = 0; i < quiet_cycles; i++)
            step_cycle();

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+source
source/core_pkg.sv
source/pipeline_control.sv
source/credit_counter.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/core_top.sv
test/core_props.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f --top-module core_tb \
    --Mdir obj_dir -o core_sim

# the verdict comes from the pass line in the output
output=$(./obj_dir/core_sim 2>&1) || true
echo "$output"
echo "$output" | grep -qx "Everything OK"

// ==== test/core_input.txt ====
# p: four program words in hex, c: 16 cycles of credit return, leftmost first
# e: expected retire record, destination register in decimal and value in hex
p 20010005 2002fffd 00221820 00612022
p 0081282a 0024302a 00223824 00224025
p 00210020 20290007 01295020 10210002
p 200b0001 200c0002 14210005 200d07ff
p 08000013 200e0009 200f0009 21b0ffff
p 02058825 fc000000 20120001 20130002
c 0000000000000000
c 0000000000000000
c 1010110011101111
e 1 00000005
e 2 fffffffd
e 3 00000002
e 4 fffffffd
e 5 00000001
e 6 00000000
e 7 00000005
e 8 fffffffd
e 9 0000000c
e 10 00000018
e 13 000007ff
e 16 000007fe
e 17 000007ff
